/* rtl/dcache_cfg_pkg.sv */
package dcache_cfg_pkg;

  // physical address layout
  localparam int PADDR_W  = 32;
  localparam int OFFSET_W = 3;
  localparam int INDEX_W  = 4;
  localparam int TAG_LOW  = OFFSET_W + INDEX_W;
  localparam int TAG_W    = PADDR_W - TAG_LOW;
  localparam int SET_NUM  = 1 << INDEX_W;

  // one line per set entry
  localparam int LINE_W = 64;
  localparam int LINE_B = LINE_W / 8;

  // defaults used by the top level
  localparam int DEF_PORT_NUM = 3;
  localparam int DEF_WAY_NUM  = 2;

  // set index sits just above the byte offset
  function automatic logic [INDEX_W-1:0] get_index(input logic [PADDR_W-1:0] paddr);
    return paddr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [TAG_W-1:0] get_tag(input logic [PADDR_W-1:0] paddr);
    return paddr[PADDR_W-1:TAG_LOW];
  endfunction

endpackage

/* rtl/dcache_types_pkg.sv */
package dcache_types_pkg;

  import dcache_cfg_pkg::*;

  // way number field in the update request
  localparam int WAY_SEL_W = 8;

  typedef logic [LINE_W-1:0] dc_line_t;

  // one lookup request from a read port
  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
  } dc_read_req_t;

  // stage-1 answer to a read port
  typedef struct packed {
    logic     hit;
    logic     miss;
    logic     conflict;
    dc_line_t data;
  } dc_read_resp_t;

  // line fill into one way
  typedef struct packed {
    logic                 valid;
    logic [WAY_SEL_W-1:0] way;
    logic [PADDR_W-1:0]   paddr;
    logic [LINE_B-1:0]    be;
    dc_line_t             data;
  } dc_update_t;

endpackage

/* rtl/dcache_lookup_if.sv */
interface dcache_lookup_if
  import dcache_cfg_pkg::*;
#(
  parameter int PORT_NUM = DEF_PORT_NUM,
  parameter int WAY_NUM  = DEF_WAY_NUM
) ();

  // stage 0 array access, shared by all ways
  logic               valid;
  logic               wr;
  logic [WAY_NUM-1:0] wr_way_oh;
  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0]   tag;
  logic [LINE_B-1:0]  be;
  logic [LINE_W-1:0]  wdata;

  // stage 1 context, registered by the arbiter
  logic [PORT_NUM-1:0] req_valid;
  logic [PORT_NUM-1:0] sel_oh;
  logic [PORT_NUM-1:0] same_index;
  logic [TAG_W-1:0]    port_tag [PORT_NUM];
  logic                upd;

  modport arb_mp (
    output valid, wr, wr_way_oh, index, tag, be, wdata
  );

  modport way_mp (
    input valid, wr, wr_way_oh, index, tag, be, wdata
  );

  modport ctx_mp (
    output req_valid, sel_oh, same_index, port_tag, upd
  );

  modport resp_mp (
    input req_valid, sel_oh, same_index, port_tag, upd
  );

endinterface

/* rtl/onehot_mux.sv */
module onehot_mux #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  logic [WORDS-1:0] i_oh,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  logic [$bits(T)-1:0] w_acc;

  // and-or select, zero when nothing is picked
  always_comb begin
    w_acc = '0;
    for (int i = 0; i < WORDS; i++) begin
      w_acc = w_acc | ({$bits(T){i_oh[i]}} & i_data[i]);
    end
  end

  assign o_selected = T'(w_acc);

endmodule

/* rtl/dcache_port_arbiter.sv */
module dcache_port_arbiter
  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;
#(
  parameter int PORT_NUM = DEF_PORT_NUM
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  dc_update_t             i_update,
  input  dc_read_req_t           i_read_req [PORT_NUM],
  dcache_lookup_if.arb_mp        lookup,
  dcache_lookup_if.ctx_mp        ctx
);

  logic [PORT_NUM-1:0] w_rd_valid;
  logic [PORT_NUM-1:0] w_sel_oh;
  logic [PORT_NUM-1:0] w_same_index;
  dc_read_req_t        w_sel_req;
  logic [PADDR_W-1:0]  w_lookup_paddr;

  for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
    assign w_rd_valid[p] = i_read_req[p].valid;
    // ports sharing the looked-up set can reuse its read data
    assign w_same_index[p] = get_index(i_read_req[p].paddr) == lookup.index;
  end

  // isolate lowest requesting port
  assign w_sel_oh = w_rd_valid & (~w_rd_valid + 1'b1);

  onehot_mux #(
    .T     (dc_read_req_t),
    .WORDS (PORT_NUM)
  ) u_req_sel (
    .i_oh       (w_sel_oh),
    .i_data     (i_read_req),
    .o_selected (w_sel_req)
  );

  // update wins the arrays over any read
  assign w_lookup_paddr = i_update.valid ? i_update.paddr : w_sel_req.paddr;

  assign lookup.valid = i_update.valid | (|w_rd_valid);
  assign lookup.wr    = i_update.valid;
  assign lookup.index = get_index(w_lookup_paddr);
  assign lookup.tag   = get_tag(i_update.paddr);
  assign lookup.be    = i_update.be;
  assign lookup.wdata = i_update.data;

  // decode way number into a per-way write strobe
  always_comb begin
    for (int w = 0; w < $bits(lookup.wr_way_oh); w++) begin
      lookup.wr_way_oh[w] = i_update.valid && (i_update.way == WAY_SEL_W'(w));
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      ctx.req_valid  <= '0;
      ctx.sel_oh     <= '0;
      ctx.same_index <= '0;
      ctx.upd        <= 1'b0;
    end else begin
      ctx.req_valid  <= w_rd_valid;
      ctx.sel_oh     <= w_sel_oh;
      ctx.same_index <= w_same_index;
      ctx.upd        <= i_update.valid;
    end
  end

  // each port compares its own tag in stage 1
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < PORT_NUM; p++) begin
      ctx.port_tag[p] <= get_tag(i_read_req[p].paddr);
    end
  end

endmodule

/* rtl/dcache_way_array.sv */
module dcache_way_array
  import dcache_cfg_pkg::*;
#(
  parameter int WAY_ID = 0
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  dcache_lookup_if.way_mp   lookup,
  output logic [TAG_W-1:0]  o_tag,
  output logic              o_tag_valid,
  output logic [LINE_W-1:0] o_data
);

  logic [TAG_W-1:0]  r_tag_mem  [SET_NUM];
  logic [LINE_W-1:0] r_data_mem [SET_NUM];
  logic [SET_NUM-1:0] r_valid;
  logic               w_wr;
  logic               w_rd;

  // write only when this way is the target
  assign w_wr = lookup.wr & lookup.wr_way_oh[WAY_ID];
  assign w_rd = lookup.valid & ~lookup.wr;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (w_wr) begin
      r_valid[lookup.index] <= 1'b1;
    end
  end

  // tag and byte-enabled line storage
  always_ff @(posedge i_clk) begin
    if (w_wr) begin
      r_tag_mem[lookup.index] <= lookup.tag;
      for (int b = 0; b < LINE_B; b++) begin
        if (lookup.be[b]) begin
          r_data_mem[lookup.index][b*8 +: 8] <= lookup.wdata[b*8 +: 8];
        end
      end
    end
  end

  // synchronous read, held while no lookup is presented
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_tag_valid <= 1'b0;
    end else if (w_rd) begin
      o_tag_valid <= r_valid[lookup.index];
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_rd) begin
      o_tag  <= r_tag_mem[lookup.index];
      o_data <= r_data_mem[lookup.index];
    end
  end

endmodule

/* rtl/dcache_resp_gen.sv */
module dcache_resp_gen
  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;
#(
  parameter int PORT_NUM = DEF_PORT_NUM,
  parameter int WAY_NUM  = DEF_WAY_NUM
) (
  dcache_lookup_if.resp_mp   ctx,
  input  logic [TAG_W-1:0]   i_way_tag [WAY_NUM],
  input  logic [WAY_NUM-1:0] i_way_tag_valid,
  input  dc_line_t           i_way_data [WAY_NUM],
  output dc_read_resp_t      o_read_resp [PORT_NUM]
);

  for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
    logic [WAY_NUM-1:0] w_hit_way;
    logic               w_any_hit;
    logic               w_served;
    dc_line_t           w_hit_data;

    // per-way tag match against this port's address
    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
      assign w_hit_way[w] = i_way_tag_valid[w] & (i_way_tag[w] == ctx.port_tag[p]);
    end

    assign w_any_hit = |w_hit_way;

    onehot_mux #(
      .T     (dc_line_t),
      .WORDS (WAY_NUM)
    ) u_data_sel (
      .i_oh       (w_hit_way),
      .i_data     (i_way_data),
      .o_selected (w_hit_data)
    );

    // served when picked, or when sharing the picked set,
    // and never in an update cycle
    assign w_served = ctx.req_valid[p] & ~ctx.upd &
                      (ctx.sel_oh[p] | ctx.same_index[p]);

    assign o_read_resp[p].hit      = w_served & w_any_hit;
    assign o_read_resp[p].miss     = w_served & ~w_any_hit;
    // everything else that asked must retry
    assign o_read_resp[p].conflict = ctx.req_valid[p] & ~w_served;
    assign o_read_resp[p].data     = (w_served & w_any_hit) ? w_hit_data : '0;
  end

endmodule

/* rtl/dcache_array_top.sv */
module dcache_array_top
  import dcache_cfg_pkg::*;
  import dcache_types_pkg::*;
#(
  parameter int PORT_NUM = DEF_PORT_NUM,
  parameter int WAY_NUM  = DEF_WAY_NUM
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  // line update
  input  logic                         i_upd_valid,
  input  logic [WAY_SEL_W-1:0]         i_upd_way,
  input  logic [PADDR_W-1:0]           i_upd_paddr,
  input  logic [LINE_B-1:0]            i_upd_be,
  input  logic [LINE_W-1:0]            i_upd_data,
  // read ports, flattened with port 0 in the low bits
  input  logic [PORT_NUM-1:0]          i_rd_valid,
  input  logic [PORT_NUM*PADDR_W-1:0]  i_rd_paddr,
  output logic [PORT_NUM-1:0]          o_rd_hit,
  output logic [PORT_NUM-1:0]          o_rd_miss,
  output logic [PORT_NUM-1:0]          o_rd_conflict,
  output logic [PORT_NUM*LINE_W-1:0]   o_rd_data
);

  dc_update_t    w_update;
  dc_read_req_t  w_read_req  [PORT_NUM];
  dc_read_resp_t w_read_resp [PORT_NUM];

  logic [TAG_W-1:0]   w_way_tag [WAY_NUM];
  logic [WAY_NUM-1:0] w_way_tag_valid;
  dc_line_t           w_way_data [WAY_NUM];

  assign w_update.valid = i_upd_valid;
  assign w_update.way   = i_upd_way;
  assign w_update.paddr = i_upd_paddr;
  assign w_update.be    = i_upd_be;
  assign w_update.data  = i_upd_data;

  for (genvar p = 0; p < PORT_NUM; p++) begin : g_port
    assign w_read_req[p].valid = i_rd_valid[p];
    assign w_read_req[p].paddr = i_rd_paddr[p*PADDR_W +: PADDR_W];

    assign o_rd_hit[p]                   = w_read_resp[p].hit;
    assign o_rd_miss[p]                  = w_read_resp[p].miss;
    assign o_rd_conflict[p]              = w_read_resp[p].conflict;
    assign o_rd_data[p*LINE_W +: LINE_W] = w_read_resp[p].data;
  end

  dcache_lookup_if #(
    .PORT_NUM (PORT_NUM),
    .WAY_NUM  (WAY_NUM)
  ) u_lookup ();

  dcache_port_arbiter #(
    .PORT_NUM (PORT_NUM)
  ) u_arbiter (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_update   (w_update),
    .i_read_req (w_read_req),
    .lookup     (u_lookup.arb_mp),
    .ctx        (u_lookup.ctx_mp)
  );

  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    dcache_way_array #(
      .WAY_ID (w)
    ) u_way (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .lookup      (u_lookup.way_mp),
      .o_tag       (w_way_tag[w]),
      .o_tag_valid (w_way_tag_valid[w]),
      .o_data      (w_way_data[w])
    );
  end

  dcache_resp_gen #(
    .PORT_NUM (PORT_NUM),
    .WAY_NUM  (WAY_NUM)
  ) u_resp_gen (
    .ctx             (u_lookup.resp_mp),
    .i_way_tag       (w_way_tag),
    .i_way_tag_valid (w_way_tag_valid),
    .i_way_data      (w_way_data),
    .o_read_resp     (w_read_resp)
  );

endmodule

/* tests/dcache_tb.sv */
module dcache_tb
  import dcache_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PORT_NUM        = DEF_PORT_NUM;
  localparam int WAY_NUM         = DEF_WAY_NUM;
  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 92;
  localparam int RANDOM_CYCLES   = 400;
  // about four times the full sequence
  localparam int MAX_CYCLES = 4 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);
  localparam logic [TAG_W-1:0] TAG_BASE = TAG_W'(32'h0a5c3);

  logic                        i_clk;
  logic                        i_reset_n;
  logic                        i_upd_valid;
  logic [7:0]                  i_upd_way;
  logic [PADDR_W-1:0]          i_upd_paddr;
  logic [LINE_B-1:0]           i_upd_be;
  logic [LINE_W-1:0]           i_upd_data;
  logic [PORT_NUM-1:0]         i_rd_valid;
  logic [PORT_NUM*PADDR_W-1:0] i_rd_paddr;
  logic [PORT_NUM-1:0]         o_rd_hit;
  logic [PORT_NUM-1:0]         o_rd_miss;
  logic [PORT_NUM-1:0]         o_rd_conflict;
  logic [PORT_NUM*LINE_W-1:0]  o_rd_data;

  // shadow copy of the cache contents
  logic [TAG_W-1:0]    sh_tag   [WAY_NUM][SET_NUM];
  logic                sh_valid [WAY_NUM][SET_NUM];
  logic [LINE_W-1:0]   sh_data  [WAY_NUM][SET_NUM];
  logic [PORT_NUM-1:0] exp_hit;
  logic [PORT_NUM-1:0] exp_miss;
  logic [PORT_NUM-1:0] exp_conflict;
  logic [LINE_W-1:0]   exp_data [PORT_NUM];

  int     errors;
  int     cycle_cnt;
  int     hit_cnt;
  int     miss_cnt;
  int     conflict_cnt;
  logic   check_en;
  integer seed;

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  dcache_array_top #(
    .PORT_NUM (PORT_NUM),
    .WAY_NUM  (WAY_NUM)
  ) dcache_array_top_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_upd_valid   (i_upd_valid),
    .i_upd_way     (i_upd_way),
    .i_upd_paddr   (i_upd_paddr),
    .i_upd_be      (i_upd_be),
    .i_upd_data    (i_upd_data),
    .i_rd_valid    (i_rd_valid),
    .i_rd_paddr    (i_rd_paddr),
    .o_rd_hit      (o_rd_hit),
    .o_rd_miss     (o_rd_miss),
    .o_rd_conflict (o_rd_conflict),
    .o_rd_data     (o_rd_data)
  );

  // expected answers for the inputs sampled at this edge before the update is applied
  function void expect_resp(
    input logic                        upd_valid,
    input logic [7:0]                  upd_way,
    input logic [PADDR_W-1:0]          upd_paddr,
    input logic [LINE_B-1:0]           upd_be,
    input logic [LINE_W-1:0]           upd_data,
    input logic [PORT_NUM-1:0]         rd_valid,
    input logic [PORT_NUM*PADDR_W-1:0] rd_paddr
  );
    logic [INDEX_W-1:0] idx;
    logic [INDEX_W-1:0] sel_idx;
    logic [TAG_W-1:0]   tag;
    logic [PADDR_W-1:0] addr;
    int                 sel;
    exp_hit      = '0;
    exp_miss     = '0;
    exp_conflict = '0;
    sel_idx      = '0;
    sel          = -1;
    for (int p = 0; p < PORT_NUM; p++) begin
      exp_data[p] = '0;
    end
    if (upd_valid) begin
      // every reader retries while the arrays are written
      exp_conflict = rd_valid;
      idx = upd_paddr[OFFSET_W +: INDEX_W];
      if (upd_way < WAY_NUM) begin
        sh_valid[upd_way][idx] = 1'b1;
        sh_tag[upd_way][idx]   = upd_paddr[PADDR_W-1 -: TAG_W];
        for (int b = 0; b < LINE_B; b++) begin
          if (upd_be[b]) begin
            sh_data[upd_way][idx][b*8 +: 8] = upd_data[b*8 +: 8];
          end
        end
      end
    end else begin
      for (int p = PORT_NUM - 1; p >= 0; p--) begin
        if (rd_valid[p]) begin
          sel = p;
        end
      end
      if (sel >= 0) begin
        sel_idx = rd_paddr[sel*PADDR_W + OFFSET_W +: INDEX_W];
      end
      for (int p = 0; p < PORT_NUM; p++) begin
        if (rd_valid[p]) begin
          addr = rd_paddr[p*PADDR_W +: PADDR_W];
          idx  = addr[OFFSET_W +: INDEX_W];
          tag  = addr[PADDR_W-1 -: TAG_W];
          if (p == sel || idx == sel_idx) begin
            exp_miss[p] = 1'b1;
            for (int w = 0; w < WAY_NUM; w++) begin
              if (sh_valid[w][idx] && sh_tag[w][idx] == tag) begin
                exp_hit[p]  = 1'b1;
                exp_miss[p] = 1'b0;
                exp_data[p] = sh_data[w][idx];
              end
            end
          end else begin
            exp_conflict[p] = 1'b1;
          end
        end
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [LINE_W-1:0] expected,
                             input logic [LINE_W-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  function automatic logic [PADDR_W-1:0] make_addr(input int tag_sel, input int idx,
                                                   input int off);
    logic [TAG_W-1:0] tag;
    tag = TAG_BASE + TAG_W'(tag_sel);
    return {tag, INDEX_W'(idx), OFFSET_W'(off)};
  endfunction

  task automatic set_idle();
    i_upd_valid = 1'b0;
    i_upd_way   = '0;
    i_upd_paddr = '0;
    i_upd_be    = '0;
    i_upd_data  = '0;
    i_rd_valid  = '0;
    i_rd_paddr  = '0;
  endtask

  // wait for the next drive point and clear all requests
  task automatic step();
    @(posedge i_clk);
    #2;
    set_idle();
  endtask

  task automatic drive_update(input int way, input logic [PADDR_W-1:0] paddr,
                              input logic [LINE_B-1:0] be, input logic [LINE_W-1:0] data);
    i_upd_valid = 1'b1;
    i_upd_way   = 8'(way);
    i_upd_paddr = paddr;
    i_upd_be    = be;
    i_upd_data  = data;
  endtask

  task automatic drive_read(input int port, input logic [PADDR_W-1:0] paddr);
    i_rd_valid[port]                     = 1'b1;
    i_rd_paddr[port*PADDR_W +: PADDR_W] = paddr;
  endtask

  // inputs still hold what was sampled at this edge
  always @(posedge i_clk) begin
    if (check_en) begin
      #1;
      expect_resp(i_upd_valid, i_upd_way, i_upd_paddr, i_upd_be, i_upd_data,
                  i_rd_valid, i_rd_paddr);
      hit_cnt      += $countones(exp_hit);
      miss_cnt     += $countones(exp_miss);
      conflict_cnt += $countones(exp_conflict);
      check_value("o_rd_hit", LINE_W'(exp_hit), LINE_W'(o_rd_hit));
      check_value("o_rd_miss", LINE_W'(exp_miss), LINE_W'(o_rd_miss));
      check_value("o_rd_conflict", LINE_W'(exp_conflict), LINE_W'(o_rd_conflict));
      for (int p = 0; p < PORT_NUM; p++) begin
        check_value($sformatf("o_rd_data[%0d]", p), exp_data[p], o_rd_data[p*LINE_W +: LINE_W]);
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [PADDR_W-1:0] addr_a;
    logic [PADDR_W-1:0] addr_b;
    logic [PADDR_W-1:0] addr_c;
    logic [LINE_B-1:0]  be;
    int                 way;
    int                 idx;
    seed         = 32'h4f06c4d7;
    errors       = 0;
    cycle_cnt    = 0;
    hit_cnt      = 0;
    miss_cnt     = 0;
    conflict_cnt = 0;
    check_en     = 1'b0;
    for (int w = 0; w < WAY_NUM; w++) begin
      for (int s = 0; s < SET_NUM; s++) begin
        sh_valid[w][s] = 1'b0;
        sh_tag[w][s]   = '0;
        sh_data[w][s]  = '0;
      end
    end
    i_reset_n = 1'b0;
    set_idle();
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;
    check_en  = 1'b1;

    // idle cycles and single-port reads on an empty cache
    step();
    step();
    for (int p = 0; p < PORT_NUM; p++) begin
      step();
      drive_read(p, make_addr(p, p, 0));
    end
    // fill a line then read it back and try another tag in the same set
    addr_a = make_addr(0, 5, 0);
    addr_b = make_addr(1, 5, 0);
    addr_c = make_addr(2, 9, 0);
    step();
    drive_update(0, addr_a, '1, 64'h0123_4567_89ab_cdef);
    step();
    drive_read(0, addr_a);
    step();
    drive_read(1, addr_b);
    // low four bytes only
    step();
    drive_update(0, addr_a, 8'h0f, 64'hffee_ddcc_bbaa_9988);
    step();
    drive_read(2, addr_a);
    // several ports at once with set 5 shared by ports 0 and 1
    step();
    drive_update(1, addr_c, '1, 64'h5555_aaaa_3c3c_c3c3);
    step();
    drive_read(0, addr_b);
    drive_read(1, addr_a);
    drive_read(2, addr_c);
    step();
    drive_read(1, addr_c);
    drive_read(2, addr_a);
    // reads beside an update and then reads of the new line
    step();
    drive_update(1, addr_b, '1, 64'h1111_2222_3333_4444);
    for (int p = 0; p < PORT_NUM; p++) begin
      drive_read(p, addr_b);
    end
    step();
    for (int p = 0; p < PORT_NUM; p++) begin
      drive_read(p, addr_b);
    end
    // response counts cover the random mix only
    step();
    hit_cnt      = 0;
    miss_cnt     = 0;
    conflict_cnt = 0;

    // small tag pool and four sets keep hits and collisions frequent
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      step();
      if (($random(seed) & 3) == 0) begin
        idx    = $random(seed) & 3;
        addr_a = make_addr($random(seed) & 3, idx, 0);
        way    = ($random(seed) & 32'h7fff_ffff) % WAY_NUM;
        // keep a tag in one way per set
        for (int w = 0; w < WAY_NUM; w++) begin
          if (sh_valid[w][idx] && sh_tag[w][idx] == addr_a[PADDR_W-1 -: TAG_W]) begin
            way = w;
          end
        end
        be = sh_valid[way][idx] ? LINE_B'($random(seed)) : '1;
        drive_update(way, addr_a, be, {$random(seed), $random(seed)});
      end
      for (int p = 0; p < PORT_NUM; p++) begin
        if ($random(seed) & 1) begin
          drive_read(p, make_addr($random(seed) & 3, $random(seed) & 3, $random(seed) & 7));
        end
      end
    end
    step();
    step();
    #5;
    check_en = 1'b0;

    if (hit_cnt == 0 || miss_cnt == 0 || conflict_cnt == 0) begin
      errors++;
      $display("random mix incomplete: %0d hits, %0d misses, %0d conflicts",
               hit_cnt, miss_cnt, conflict_cnt);
    end
    $display("run complete: %0d errors over %0d cycles", errors, cycle_cnt);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/dcache_cfg_pkg.sv
rtl/dcache_types_pkg.sv
rtl/dcache_lookup_if.sv
rtl/onehot_mux.sv
rtl/dcache_port_arbiter.sv
rtl/dcache_way_array.sv
rtl/dcache_resp_gen.sv
rtl/dcache_array_top.sv
tests/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f compile.f --top-module dcache_tb -o dcache_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure"
exit 0
